/* rtl/vfp_pkg.sv */
/* Vector FP execute shared types
   Operand words, op codes and the structs passed between pipeline stages */
package vfp_pkg;

	// Single-precision word, also one lane result
	typedef logic [31:0] scalar_t;

	// Biased exponent field
	typedef logic [7:0] exponent_t;

	// Significand including the hidden bit
	typedef logic [23:0] significand_t;

	// Caller label that rides along with an operation
	typedef logic [3:0] tag_t;

	// Operation codes
	typedef enum logic [2:0]
	{
		OP_FADD = 3'd0,
		OP_FSUB = 3'd1,
		OP_FMUL = 3'd2,
		OP_FGTR = 3'd3,
		OP_FLT  = 3'd4
	} vfp_op_t;

	// Per-operation control carried beside the lanes
	typedef struct packed
	{
		logic    valid;
		vfp_op_t op;
		tag_t    tag;
	} pipe_ctrl_t;

	// What one lane receives each cycle
	typedef struct packed
	{
		scalar_t a;
		scalar_t b;
		vfp_op_t op;
	} lane_operands_t;

	// What one lane returns
	typedef struct packed
	{
		scalar_t value;
		logic    is_nan;
	} lane_result_t;

	localparam int unsigned EXP_BIAS = 127;

	// Quiet NaN returned by every invalid operation
	localparam scalar_t QNAN = 32'h7fffffff;

endpackage

/* rtl/vfp_issue.sv */
/* Issue stage
   Registers one operation and splits the operand vectors into lane structs */
module vfp_issue #(
	parameter int LANES = 4
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  in_valid,
	input  vfp_pkg::vfp_op_t                      in_op,
	input  vfp_pkg::tag_t                         in_tag,
	input  logic [LANES-1:0]                      in_mask,
	input  vfp_pkg::scalar_t [LANES-1:0]          in_a,
	input  vfp_pkg::scalar_t [LANES-1:0]          in_b,
	output vfp_pkg::pipe_ctrl_t                   issue_ctrl,
	output logic [LANES-1:0]                      issue_mask,
	output vfp_pkg::lane_operands_t [LANES-1:0]   lane_in
);

	logic is_sub;

	// Subtract becomes add with b negated
	assign is_sub = in_op == vfp_pkg::OP_FSUB;

	// Control word, cleared by reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			issue_ctrl <= '0;
		else
			issue_ctrl <= '{valid: in_valid, op: in_op, tag: in_tag};
	end

	// Operand payload, captured every cycle
	always_ff @(posedge clk)
	begin
		issue_mask <= in_mask;
		for (int i = 0; i < LANES; i++)
		begin
			lane_in[i].a <= in_a[i];
			// Flip only the sign bit of b on subtract
			lane_in[i].b <= is_sub ? {~in_b[i][31], in_b[i][30:0]} : in_b[i];
			// Lanes never see OP_FSUB
			lane_in[i].op <= is_sub ? vfp_pkg::OP_FADD : in_op;
		end
	end

	// Op code must be one of the defined encodings when issued
	a_legal_op: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> in_op inside {vfp_pkg::OP_FADD, vfp_pkg::OP_FSUB, vfp_pkg::OP_FMUL,
			vfp_pkg::OP_FGTR, vfp_pkg::OP_FLT})
		else $error("illegal op code issued");

endmodule

/* rtl/vfp_lane.sv */
/* FP lane datapath
   Stage A aligns and adds or multiplies, stage B normalizes, rounds and selects */
module vfp_lane (
	input  logic                    clk,
	input  vfp_pkg::lane_operands_t lane_in,
	output vfp_pkg::lane_result_t   lane_out
);

	// Stage A combinational
	logic                  is_mul;
	logic                  is_cmp;
	logic                  sign_a;
	logic                  sign_b;
	vfp_pkg::exponent_t    exp_a;
	vfp_pkg::exponent_t    exp_b;
	vfp_pkg::exponent_t    exp_big;
	vfp_pkg::exponent_t    exp_diff;
	vfp_pkg::significand_t sig_a;
	vfp_pkg::significand_t sig_b;
	vfp_pkg::significand_t sig_big;
	vfp_pkg::significand_t sig_small;
	logic                  zero_a;
	logic                  zero_b;
	logic                  inf_a;
	logic                  inf_b;
	logic                  nan_a;
	logic                  nan_b;
	logic                  a_larger;
	logic                  logical_sub;
	logic [26:0]           aligned_small;
	logic [26:0]           sum;
	logic [47:0]           product;
	logic signed [9:0]     mul_exp;
	logic                  res_sign;
	logic                  res_nan;
	logic                  res_inf;

	// Stage A registers
	vfp_pkg::vfp_op_t      a_op;
	logic                  a_sign;
	logic                  a_nan;
	logic                  a_inf;
	vfp_pkg::exponent_t    a_exp;
	logic [26:0]           a_sum;
	logic [47:0]           a_prod;
	logic signed [9:0]     a_mul_exp;

	// Stage B combinational
	logic [4:0]            lz;
	logic [26:0]           norm_sum;
	vfp_pkg::significand_t pre_sig;
	logic                  round_bit;
	logic signed [9:0]     pre_exp;
	logic [24:0]           rounded;
	logic signed [9:0]     final_exp;
	logic                  diff_zero;
	vfp_pkg::lane_result_t result;

	// Leading zeros of the 27-bit sum, 27 when it is zero
	function automatic logic [4:0] count_lz(input logic [26:0] value);
		logic [4:0] count;
		logic       found;
		count = 5'd27;
		found = 1'b0;
		for (int i = 26; i >= 0; i--)
		begin
			if (!found && value[i])
			begin
				count = 5'(26 - i);
				found = 1'b1;
			end
		end
		return count;
	endfunction

	always_comb
	begin
		is_mul = lane_in.op == vfp_pkg::OP_FMUL;
		is_cmp = lane_in.op == vfp_pkg::OP_FGTR || lane_in.op == vfp_pkg::OP_FLT;
		// Compares evaluate a minus b
		sign_a = lane_in.a[31];
		sign_b = lane_in.b[31] ^ is_cmp;
		exp_a = lane_in.a[30:23];
		exp_b = lane_in.b[30:23];
		// Denormals count as zero
		zero_a = exp_a == '0;
		zero_b = exp_b == '0;
		inf_a = exp_a == 8'hff && lane_in.a[22:0] == '0;
		inf_b = exp_b == 8'hff && lane_in.b[22:0] == '0;
		nan_a = exp_a == 8'hff && lane_in.a[22:0] != '0;
		nan_b = exp_b == 8'hff && lane_in.b[22:0] != '0;
		sig_a = zero_a ? '0 : {1'b1, lane_in.a[22:0]};
		sig_b = zero_b ? '0 : {1'b1, lane_in.b[22:0]};

		// Order by magnitude so the difference is never negative
		a_larger = lane_in.a[30:0] >= lane_in.b[30:0];
		exp_big = a_larger ? exp_a : exp_b;
		exp_diff = a_larger ? exp_a - exp_b : exp_b - exp_a;
		sig_big = a_larger ? sig_a : sig_b;
		sig_small = a_larger ? sig_b : sig_a;
		// Carry bit on top, two guard bits below
		aligned_small = {1'b0, sig_small, 2'b00} >> exp_diff;
		logical_sub = sign_a ^ sign_b;
		if (logical_sub)
			sum = {1'b0, sig_big, 2'b00} - aligned_small;
		else
			sum = {1'b0, sig_big, 2'b00} + aligned_small;

		// Multiply path
		product = 48'(sig_a) * 48'(sig_b);
		mul_exp = 10'(exp_a) + 10'(exp_b) - 10'(vfp_pkg::EXP_BIAS);

		res_sign = is_mul ? sign_a ^ sign_b : (a_larger ? sign_a : sign_b);

		// Special cases per op class
		if (is_mul)
		begin
			res_nan = nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a);
			res_inf = inf_a || inf_b;
		end
		else if (is_cmp)
		begin
			// Infinities compare through the normal difference
			res_nan = nan_a || nan_b;
			res_inf = 1'b0;
		end
		else
		begin
			res_nan = nan_a || nan_b || (inf_a && inf_b && logical_sub);
			res_inf = inf_a || inf_b;
		end
	end

	always_ff @(posedge clk)
	begin
		a_op <= lane_in.op;
		a_sign <= res_sign;
		a_nan <= res_nan;
		a_inf <= res_inf;
		a_exp <= exp_big;
		a_sum <= sum;
		a_prod <= product;
		a_mul_exp <= mul_exp;
	end

	always_comb
	begin
		lz = count_lz(a_sum);
		norm_sum = a_sum << lz;
		diff_zero = a_sum == '0;

		// Product needs at most a one-place shift
		if (a_op == vfp_pkg::OP_FMUL)
		begin
			if (a_prod[47])
			begin
				pre_sig = a_prod[47:24];
				round_bit = a_prod[23];
				pre_exp = a_mul_exp + 10'sd1;
			end
			else
			begin
				pre_sig = a_prod[46:23];
				round_bit = a_prod[22];
				pre_exp = a_mul_exp;
			end
		end
		else
		begin
			pre_sig = norm_sum[26:3];
			round_bit = norm_sum[2];
			pre_exp = 10'(a_exp) + 10'sd1 - 10'(lz);
		end

		// Round half up on the first dropped bit
		rounded = {1'b0, pre_sig} + 25'(round_bit);
		final_exp = pre_exp + 10'(rounded[24]);

		result.is_nan = 1'b0;
		if (a_nan)
		begin
			result.value = vfp_pkg::QNAN;
			result.is_nan = 1'b1;
		end
		else if (a_inf)
			result.value = {a_sign, 8'hff, 23'd0};
		else if (a_op == vfp_pkg::OP_FGTR)
			result.value = {31'd0, !a_sign && !diff_zero};
		else if (a_op == vfp_pkg::OP_FLT)
			result.value = {31'd0, a_sign && !diff_zero};
		else if (!pre_sig[23] || final_exp <= 10'sd0)
			result.value = '0;  // zero sum or underflow, always +0
		else if (final_exp >= 10'sd255)
			result.value = {a_sign, 8'hff, 23'd0};
		else
			result.value = {a_sign, final_exp[7:0], rounded[22:0]};
	end

	always_ff @(posedge clk)
	begin
		lane_out <= result;
	end

	// Arithmetic results never carry an all-ones exponent with a fraction
	a_no_false_nan: assert property (@(posedge clk)
		(!lane_out.is_nan && lane_out.value[30:23] == 8'hff) |-> lane_out.value[22:0] == '0)
		else $error("lane produced unflagged NaN pattern");

endmodule

/* rtl/vfp_writeback.sv */
/* Writeback stage
   Aligns control with the lanes, masks and gathers results, flags invalid ops */
module vfp_writeback #(
	parameter int LANES = 4
) (
	input  logic                                clk,
	input  logic                                reset,
	input  vfp_pkg::pipe_ctrl_t                 issue_ctrl,
	input  logic [LANES-1:0]                    issue_mask,
	input  vfp_pkg::lane_result_t [LANES-1:0]   lane_out,
	output logic                                out_valid,
	output vfp_pkg::tag_t                       out_tag,
	output logic [LANES-1:0]                    out_mask,
	output vfp_pkg::scalar_t [LANES-1:0]        out_result,
	output logic                                out_invalid
);

	// Two-deep delay matches lane stages A and B
	vfp_pkg::pipe_ctrl_t [1:0]          ctrl_d;
	logic [1:0][LANES-1:0]              mask_d;
	vfp_pkg::scalar_t [LANES-1:0]       gathered;
	logic                               any_nan;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ctrl_d <= '0;
		else
		begin
			ctrl_d[0] <= issue_ctrl;
			ctrl_d[1] <= ctrl_d[0];
		end
	end

	always_ff @(posedge clk)
	begin
		mask_d[0] <= issue_mask;
		mask_d[1] <= mask_d[0];
	end

	// Masked-off lanes read as zero and never raise invalid
	always_comb
	begin
		any_nan = 1'b0;
		for (int i = 0; i < LANES; i++)
		begin
			gathered[i] = mask_d[1][i] ? lane_out[i].value : '0;
			any_nan = any_nan | (mask_d[1][i] & lane_out[i].is_nan);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_invalid <= 1'b0;
		end
		else
		begin
			out_valid <= ctrl_d[1].valid;
			out_invalid <= ctrl_d[1].valid & any_nan;
		end
	end

	// Result payload
	always_ff @(posedge clk)
	begin
		out_tag <= ctrl_d[1].tag;
		out_mask <= mask_d[1];
		out_result <= gathered;
	end

	a_valid_known: assert property (@(posedge clk) !reset |-> !$isunknown(out_valid))
		else $error("out_valid unknown after reset");

endmodule

/* rtl/vfp_execute.sv */
/* Vector FP execute pipeline top
   Issue stage, one datapath per lane and writeback, four cycles end to end */
module vfp_execute #(
	parameter int LANES = 4
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            in_valid,
	input  vfp_pkg::vfp_op_t                in_op,
	input  vfp_pkg::tag_t                   in_tag,
	input  logic [LANES-1:0]                in_mask,
	input  vfp_pkg::scalar_t [LANES-1:0]    in_a,
	input  vfp_pkg::scalar_t [LANES-1:0]    in_b,
	output logic                            out_valid,
	output vfp_pkg::tag_t                   out_tag,
	output logic [LANES-1:0]                out_mask,
	output vfp_pkg::scalar_t [LANES-1:0]    out_result,
	output logic                            out_invalid
);

	vfp_pkg::pipe_ctrl_t                    issue_ctrl;
	logic [LANES-1:0]                       issue_mask;
	vfp_pkg::lane_operands_t [LANES-1:0]    lane_in;
	vfp_pkg::lane_result_t [LANES-1:0]      lane_out;

	vfp_issue #(.LANES(LANES)) u_issue (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_tag     (in_tag),
		.in_mask    (in_mask),
		.in_a       (in_a),
		.in_b       (in_b),
		.issue_ctrl (issue_ctrl),
		.issue_mask (issue_mask),
		.lane_in    (lane_in)
	);

	// One datapath per lane
	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		vfp_lane u_lane (
			.clk      (clk),
			.lane_in  (lane_in[i]),
			.lane_out (lane_out[i])
		);
	end

	vfp_writeback #(.LANES(LANES)) u_writeback (
		.clk         (clk),
		.reset       (reset),
		.issue_ctrl  (issue_ctrl),
		.issue_mask  (issue_mask),
		.lane_out    (lane_out),
		.out_valid   (out_valid),
		.out_tag     (out_tag),
		.out_mask    (out_mask),
		.out_result  (out_result),
		.out_invalid (out_invalid)
	);

endmodule

/* test/vfp_execute_tb.sv */
/* Vector FP execute testbench
   Directed and random operations checked against a real-arithmetic model */
module vfp_execute_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LANES = 4;
	// Drive edge, then four register stages
	localparam int RESULT_EDGES = 5;
	localparam int TIMEOUT_CYCLES = 20;

	// Operand patterns that small reals cannot express
	localparam vfp_pkg::scalar_t POS_INF = 32'h7f800000;
	localparam vfp_pkg::scalar_t NEG_INF = 32'hff800000;
	localparam vfp_pkg::scalar_t NAN_IN = 32'h7fc00000;
	localparam vfp_pkg::scalar_t BIG = 32'h71800000;   // 2^100
	localparam vfp_pkg::scalar_t TINY = 32'h0d800000;  // 2^-100

	typedef vfp_pkg::scalar_t [LANES-1:0] vec_t;

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	vfp_pkg::vfp_op_t      in_op;
	vfp_pkg::tag_t         in_tag;
	logic [LANES-1:0]      in_mask;
	vec_t                  in_a;
	vec_t                  in_b;
	logic                  out_valid;
	vfp_pkg::tag_t         out_tag;
	logic [LANES-1:0]      out_mask;
	vec_t                  out_result;
	logic                  out_invalid;

	integer seed = 84;
	int errors = 0;
	int cycle = 0;

	// Expected results in issue order
	vec_t                  q_result[$];
	vfp_pkg::tag_t         q_tag[$];
	logic [LANES-1:0]      q_mask[$];
	logic                  q_invalid[$];
	int                    q_cycle[$];

	vfp_execute #(.LANES(LANES)) u_vfp_execute (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_op       (in_op),
		.in_tag      (in_tag),
		.in_mask     (in_mask),
		.in_a        (in_a),
		.in_b        (in_b),
		.out_valid   (out_valid),
		.out_tag     (out_tag),
		.out_mask    (out_mask),
		.out_result  (out_result),
		.out_invalid (out_invalid)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Rising edges seen so far
	always @(posedge clk)
		cycle <= cycle + 1;

	// Single word to real, denormals read as zero
	function automatic real word_to_real(input vfp_pkg::scalar_t s);
		logic [10:0] e64;
		if (s[30:23] == 8'h00)
			return 0.0;
		if (s[30:23] == 8'hff)
			e64 = 11'h7ff;
		else
			e64 = 11'(s[30:23]) + 11'd896;
		return $bitstoreal({s[31], e64, s[22:0], 29'd0});
	endfunction

	// Real to single word, zero always positive, out of range to inf or +0
	function automatic vfp_pkg::scalar_t real_to_word(input real r);
		logic [63:0] bits;
		int          e;
		bits = $realtobits(r);
		if (r == 0.0)
			return '0;
		if (bits[62:52] == 11'h7ff)
			return (bits[51:0] != '0) ? vfp_pkg::QNAN : {bits[63], 8'hff, 23'd0};
		e = int'(bits[62:52]) - 1023 + 127;
		if (e >= 255)
			return {bits[63], 8'hff, 23'd0};
		if (e <= 0)
			return '0;
		return {bits[63], e[7:0], bits[51:29]};
	endfunction

	function automatic logic is_nan_word(input vfp_pkg::scalar_t s);
		return s[30:23] == 8'hff && s[22:0] != '0;
	endfunction

	// Reference result of one lane
	function automatic vfp_pkg::scalar_t lane_model(input vfp_pkg::vfp_op_t op,
		input vfp_pkg::scalar_t a, input vfp_pkg::scalar_t b);
		real ra;
		real rb;
		ra = word_to_real(a);
		rb = word_to_real(b);
		if (is_nan_word(a) || is_nan_word(b))
			return vfp_pkg::QNAN;
		case (op)
			vfp_pkg::OP_FADD: return real_to_word(ra + rb);
			vfp_pkg::OP_FSUB: return real_to_word(ra - rb);
			vfp_pkg::OP_FMUL: return real_to_word(ra * rb);
			vfp_pkg::OP_FGTR: return (ra > rb) ? 32'd1 : 32'd0;
			vfp_pkg::OP_FLT: return (ra < rb) ? 32'd1 : 32'd0;
			default: return vfp_pkg::QNAN;
		endcase
	endfunction

	function automatic vec_t pack_lanes(input vfp_pkg::scalar_t l0, input vfp_pkg::scalar_t l1,
		input vfp_pkg::scalar_t l2, input vfp_pkg::scalar_t l3);
		vec_t v;
		v[0] = l0;
		v[1] = l1;
		v[2] = l2;
		v[3] = l3;
		return v;
	endfunction

	// Small integer times a power of two, so every result stays exact
	function automatic vfp_pkg::scalar_t random_operand();
		logic [31:0] rnd;
		real         r;
		rnd = $random(seed);
		r = real'(int'(rnd[3:0])) * 2.0 ** real'(int'(rnd[6:4]) - 3);
		if (rnd[7])
			r = -r;
		return real_to_word(r);
	endfunction

	task automatic check_scalar(input vfp_pkg::scalar_t got, input vfp_pkg::scalar_t expected,
		input string what);
		if (got !== expected)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic check_flags(input logic got_inv, input logic exp_inv,
		input vfp_pkg::tag_t got_tag, input vfp_pkg::tag_t exp_tag,
		input logic [LANES-1:0] got_mask, input logic [LANES-1:0] exp_mask);
		if (got_inv !== exp_inv)
		begin
			$display("MISMATCH at %0t: tag %0d invalid %b expected %b", $time, exp_tag,
				got_inv, exp_inv);
			errors++;
		end
		if (got_tag !== exp_tag)
		begin
			$display("MISMATCH at %0t: out_tag %0d expected %0d", $time, got_tag, exp_tag);
			errors++;
		end
		if (got_mask !== exp_mask)
		begin
			$display("MISMATCH at %0t: out_mask %b expected %b", $time, got_mask, exp_mask);
			errors++;
		end
	endtask

	// Drive one operation for one cycle and queue what should come back
	task automatic issue_op(input vfp_pkg::vfp_op_t op, input vfp_pkg::tag_t tag,
		input logic [LANES-1:0] mask, input vec_t a, input vec_t b);
		vec_t             expect_vec;
		logic             expect_inv;
		vfp_pkg::scalar_t value;
		@(posedge clk);
		in_valid <= 1'b1;
		in_op <= op;
		in_tag <= tag;
		in_mask <= mask;
		in_a <= a;
		in_b <= b;
		expect_inv = 1'b0;
		for (int i = 0; i < LANES; i++)
		begin
			value = lane_model(op, a[i], b[i]);
			// Masked lanes read zero and never flag
			expect_vec[i] = mask[i] ? value : '0;
			expect_inv = expect_inv | (mask[i] & (value == vfp_pkg::QNAN));
		end
		q_result.push_back(expect_vec);
		q_tag.push_back(tag);
		q_mask.push_back(mask);
		q_invalid.push_back(expect_inv);
		q_cycle.push_back(cycle);
	endtask

	// Stop issuing, then take one result per queued operation
	task automatic drain_results();
		int   waited;
		int   exp_cycle;
		vec_t exp_vec;
		@(posedge clk);
		in_valid <= 1'b0;
		while (q_tag.size() > 0)
		begin
			waited = 0;
			@(negedge clk);
			while (!out_valid && waited < TIMEOUT_CYCLES)
			begin
				@(negedge clk);
				waited++;
			end
			if (!out_valid)
			begin
				$display("FAILURE at %0t: no result within %0d cycles, %0d still expected",
					$time, TIMEOUT_CYCLES, q_tag.size());
				errors++;
				q_result.delete();
				q_tag.delete();
				q_mask.delete();
				q_invalid.delete();
				q_cycle.delete();
			end
			else
			begin
				exp_vec = q_result.pop_front();
				exp_cycle = q_cycle.pop_front() + RESULT_EDGES;
				if (cycle != exp_cycle)
				begin
					$display("MISMATCH at %0t: result at cycle %0d expected cycle %0d",
						$time, cycle, exp_cycle);
					errors++;
				end
				for (int i = 0; i < LANES; i++)
					check_scalar(out_result[i], exp_vec[i],
						$sformatf("tag %0d lane %0d", q_tag[0], i));
				check_flags(out_invalid, q_invalid.pop_front(), out_tag, q_tag.pop_front(),
					out_mask, q_mask.pop_front());
			end
		end
	endtask

	task automatic test_reset();
		repeat (16)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
			begin
				$display("MISMATCH at %0t: out_valid %b during reset", $time, out_valid);
				errors++;
			end
		end
		@(posedge clk);
		reset <= 1'b0;
		// Still quiet until something is issued
		repeat (3)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
			begin
				$display("MISMATCH at %0t: out_valid %b with nothing issued", $time, out_valid);
				errors++;
			end
		end
	endtask

	task automatic test_add_sub();
		issue_op(vfp_pkg::OP_FADD, 4'd1, 4'b1111,
			pack_lanes(real_to_word(3.0), real_to_word(-5.5), real_to_word(1.25), real_to_word(7.0)),
			pack_lanes(real_to_word(2.0), real_to_word(2.25), real_to_word(-0.75), real_to_word(-7.0)));
		issue_op(vfp_pkg::OP_FSUB, 4'd2, 4'b1111,
			pack_lanes(real_to_word(10.0), real_to_word(-4.0), real_to_word(0.5), real_to_word(6.5)),
			pack_lanes(real_to_word(2.5), real_to_word(-1.0), real_to_word(3.0), real_to_word(6.5)));
		drain_results();
	endtask

	task automatic test_mul();
		issue_op(vfp_pkg::OP_FMUL, 4'd3, 4'b1111,
			pack_lanes(real_to_word(1.5), real_to_word(-3.0), real_to_word(0.125), real_to_word(7.0)),
			pack_lanes(real_to_word(4.0), real_to_word(0.25), real_to_word(-8.0), real_to_word(6.0)));
		// Overflow both signs, a zero product and an underflow
		issue_op(vfp_pkg::OP_FMUL, 4'd4, 4'b1111,
			pack_lanes(BIG, {1'b1, BIG[30:0]}, real_to_word(0.0), TINY),
			pack_lanes(BIG, BIG, real_to_word(5.0), TINY));
		drain_results();
	endtask

	task automatic test_compare();
		vec_t a;
		vec_t b;
		a = pack_lanes(real_to_word(3.0), real_to_word(-1.0), real_to_word(2.5), real_to_word(-0.5));
		b = pack_lanes(real_to_word(2.0), real_to_word(4.0), real_to_word(2.5), real_to_word(-0.75));
		issue_op(vfp_pkg::OP_FGTR, 4'd5, 4'b1111, a, b);
		issue_op(vfp_pkg::OP_FLT, 4'd6, 4'b1111, a, b);
		drain_results();
	endtask

	task automatic test_specials();
		issue_op(vfp_pkg::OP_FADD, 4'd7, 4'b1111,
			pack_lanes(POS_INF, NAN_IN, real_to_word(1.0), NEG_INF),
			pack_lanes(real_to_word(1.0), real_to_word(2.0), real_to_word(3.0), real_to_word(5.0)));
		// Infinity minus infinity in lane 0
		issue_op(vfp_pkg::OP_FSUB, 4'd8, 4'b1111,
			pack_lanes(POS_INF, real_to_word(4.0), real_to_word(1.0), real_to_word(2.0)),
			pack_lanes(POS_INF, real_to_word(1.0), real_to_word(1.0), real_to_word(-2.0)));
		// NaN sits in a masked lane
		issue_op(vfp_pkg::OP_FMUL, 4'd9, 4'b1101,
			pack_lanes(NEG_INF, NAN_IN, real_to_word(2.0), real_to_word(3.0)),
			pack_lanes(real_to_word(2.0), real_to_word(1.0), real_to_word(2.0), real_to_word(-1.0)));
		drain_results();
	endtask

	// Back-to-back random operations in bursts of four
	task automatic test_pipeline();
		logic [31:0] rnd;
		vec_t        a;
		vec_t        b;
		for (int n = 0; n < 12; n++)
		begin
			rnd = $random(seed);
			for (int i = 0; i < LANES; i++)
			begin
				a[i] = random_operand();
				b[i] = random_operand();
			end
			issue_op(vfp_pkg::vfp_op_t'(3'(rnd[15:8] % 8'd5)), 4'(n), rnd[LANES-1:0], a, b);
			// Drain once four ops fill the pipeline
			if (n % 4 == 3)
				drain_results();
		end
	endtask

	initial
	begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = vfp_pkg::OP_FADD;
		in_tag = '0;
		in_mask = '0;
		in_a = '0;
		in_b = '0;
		test_reset();
		test_add_sub();
		test_mul();
		test_compare();
		test_specials();
		test_pipeline();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* vfp_execute.f */
rtl/vfp_pkg.sv
rtl/vfp_issue.sv
rtl/vfp_lane.sv
rtl/vfp_writeback.sv
rtl/vfp_execute.sv
test/vfp_execute_tb.sv

/* Makefile */
BIN := obj_dir/Vvfp_execute_tb
SRCS := $(shell cat vfp_execute.f)

.PHONY: run clean

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

$(BIN): vfp_execute.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module vfp_execute_tb \
		-f vfp_execute.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log
